/* build.f */
chip_cfg_pkg.sv
tag_pkg.sv
tag_master.sv
link_ingress.sv
link_egress.sv
core_complex.sv
chip_top.sv
tb_chip_top.sv

/* Makefile */
VERILATOR  ?= verilator
TB_TOP     := tb_chip_top
RTL_TOP    := chip_top
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

# design on its own, then design with testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -F -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_chip_top.sv */
`timescale 1ns/1ps

module tb_chip_top;

  localparam int timeout_lp = 1000;
  localparam int depth_lp   = chip_cfg_pkg::link_fifo_depth_gp;
  localparam int tag_len_lp = tag_pkg::tag_packet_len_gp;

  logic                     clk_i = 1'b0;
  logic                     rst_i;
  logic                     tag_en_i;
  logic                     tag_data_i;
  chip_cfg_pkg::link_beat_s io_beat_i;
  chip_cfg_pkg::link_beat_s mem_beat_i;
  chip_cfg_pkg::link_beat_s io_beat_o;
  chip_cfg_pkg::link_beat_s mem_beat_o;
  logic                     io_tkn_o;
  logic                     mem_tkn_o;
  logic                     io_tkn_i  = 1'b0;
  logic                     mem_tkn_i = 1'b0;

  // partner side bookkeeping
  // rng state per link with io at index 0 and mem at index 1
  logic [31:0] rng_state [2];
  logic [31:0] exp_io [$];
  logic [31:0] exp_mem [$];
  logic [7:0]  cur_offset   = 8'h00;
  logic [7:0]  cur_mask     = 8'h00;
  int          io_started   = 0;
  int          mem_started  = 0;
  int          io_tkn_rx    = 0;
  int          mem_tkn_rx   = 0;
  int          io_rx_cnt    = 0;
  int          mem_rx_cnt   = 0;
  int          io_tkn_sent  = 0;
  int          mem_tkn_sent = 0;
  logic [15:0] io_acc;
  logic [31:0] mem_acc;
  int          io_nb        = 0;
  int          mem_nb       = 0;
  logic        hold_tkn     = 1'b0;
  logic        boot_phase   = 1'b1;
  logic        io_off       = 1'b1;
  logic        mem_off      = 1'b1;

  always #4 clk_i = ~clk_i;

  chip_top dut_i
    (.clk_i      ( clk_i      )
    ,.rst_i      ( rst_i      )
    ,.tag_en_i   ( tag_en_i   )
    ,.tag_data_i ( tag_data_i )
    ,.io_beat_i  ( io_beat_i  )
    ,.io_tkn_o   ( io_tkn_o   )
    ,.io_beat_o  ( io_beat_o  )
    ,.io_tkn_i   ( io_tkn_i   )
    ,.mem_beat_i ( mem_beat_i )
    ,.mem_tkn_o  ( mem_tkn_o  )
    ,.mem_beat_o ( mem_beat_o )
    ,.mem_tkn_i  ( mem_tkn_i  )
    );

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // each link thread walks its own sequence
  function automatic logic [31:0] next_rand(input bit link);
    rng_state[link] = lcg_step(rng_state[link]);
    return rng_state[link];
  endfunction

  function automatic int credits(input bit is_mem);
    return is_mem ? depth_lp + mem_tkn_rx - mem_started : depth_lp + io_tkn_rx - io_started;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // remote partner send side

  task automatic drive_beat(input bit is_mem, input logic v, input logic [7:0] d);
    if (is_mem)
      mem_beat_i <= '{v: v, data: d};
    else
      io_beat_i <= '{v: v, data: d};
  endtask

  task automatic send_word(input bit is_mem, input logic [31:0] word);
    int          beats;
    int          gap;
    int          waited;
    logic [31:0] r;
    beats  = is_mem ? 4 : 2;
    waited = 0;
    // a word may only start with a credit in hand
    while (credits(is_mem) == 0)
    begin
      @(posedge clk_i);
      waited++;
      if (waited > timeout_lp)
        stop_with_error("partner timed out waiting for a link token");
    end
    // expected output from the transform rules
    if (is_mem)
    begin
      mem_started++;
      exp_mem.push_back(word ^ {4{cur_mask}});
    end
    else
    begin
      io_started++;
      exp_io.push_back({16'h0000, word[15:0] + {8'h00, cur_offset}});
    end
    // least significant beat first with random idle gaps
    for (int b = 0; b < beats; b++)
    begin
      r   = next_rand(is_mem);
      gap = int'(r[17:16]) % 3;
      repeat (gap)
      begin
        @(posedge clk_i);
        drive_beat(is_mem, 1'b0, 8'h00);
      end
      @(posedge clk_i);
      drive_beat(is_mem, 1'b1, word[b*8 +: 8]);
    end
    @(posedge clk_i);
    drive_beat(is_mem, 1'b0, 8'h00);
  endtask

  task automatic send_burst(input bit is_mem, input int n);
    for (int i = 0; i < n; i++)
      send_word(is_mem, next_rand(is_mem));
  endtask

  // id then payload msb first
  // cut short when nbits is below the packet length
  task automatic send_tag(input logic [1:0] id, input logic [7:0] payload, input int nbits);
    logic [tag_len_lp-1:0] pkt;
    pkt = {id, payload};
    for (int i = 0; i < nbits; i++)
    begin
      @(posedge clk_i);
      tag_en_i   <= 1'b1;
      tag_data_i <= pkt[tag_len_lp-1-i];
    end
    @(posedge clk_i);
    tag_en_i <= 1'b0;
    // client register written one edge after the last bit
    repeat (2) @(posedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // remote partner receive side

  task automatic check_word(input bit is_mem, input logic [31:0] got);
    logic [31:0] exp;
    if (is_mem)
    begin
      assert (exp_mem.size() != 0)
        else stop_with_error("mem link sent a word that was never fed in");
      exp = exp_mem.pop_front();
      assert (got == exp)
        else stop_with_error($sformatf("FAIL mem_beat_o word 0x%08h, expected 0x%08h", got, exp));
    end
    else
    begin
      assert (exp_io.size() != 0)
        else stop_with_error("io link sent a word that was never fed in");
      exp = exp_io.pop_front();
      assert (got == exp)
        else stop_with_error($sformatf("FAIL io_beat_o word 0x%04h, expected 0x%04h",
                                       got[15:0], exp[15:0]));
    end
  endtask

  // reassemble output beats with the low beat first
  always @(posedge clk_i)
  begin
    if (!rst_i && io_beat_o.v)
    begin
      io_acc = {io_beat_o.data, io_acc[15:8]};
      io_nb++;
      if (io_nb == 2)
      begin
        io_nb = 0;
        check_word(1'b0, {16'h0000, io_acc});
        io_rx_cnt <= io_rx_cnt + 1;
      end
    end
    if (!rst_i && mem_beat_o.v)
    begin
      mem_acc = {mem_beat_o.data, mem_acc[31:8]};
      mem_nb++;
      if (mem_nb == 4)
      begin
        mem_nb = 0;
        check_word(1'b1, mem_acc);
        mem_rx_cnt <= mem_rx_cnt + 1;
      end
    end
  end

  // one token back per captured word
  // none go back while hold_tkn is set
  always @(posedge clk_i)
  begin
    io_tkn_i  <= 1'b0;
    mem_tkn_i <= 1'b0;
    if (!rst_i && !hold_tkn)
    begin
      if (io_tkn_sent < io_rx_cnt)
      begin
        io_tkn_i    <= 1'b1;
        io_tkn_sent <= io_tkn_sent + 1;
      end
      if (mem_tkn_sent < mem_rx_cnt)
      begin
        mem_tkn_i    <= 1'b1;
        mem_tkn_sent <= mem_tkn_sent + 1;
      end
    end
  end

  // tokens from the chip refill the partner credits
  always @(posedge clk_i)
  begin
    if (!rst_i && io_tkn_o)
      io_tkn_rx <= io_tkn_rx + 1;
    if (!rst_i && mem_tkn_o)
      mem_tkn_rx <= mem_tkn_rx + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // protocol checks

  io_quiet_a: assert property (@(posedge clk_i) disable iff (rst_i) io_off |-> !io_beat_o.v)
    else stop_with_error($sformatf("FAIL io_beat_o.v 0x%h on a disabled link", io_beat_o.v));

  mem_quiet_a: assert property (@(posedge clk_i) disable iff (rst_i) mem_off |-> !mem_beat_o.v)
    else stop_with_error($sformatf("FAIL mem_beat_o.v 0x%h on a disabled link", mem_beat_o.v));

  // before link_en only the core stage can take a word
  boot_tkn_a: assert property (@(posedge clk_i) disable iff (rst_i)
    boot_phase |-> (io_tkn_rx <= 1) && (mem_tkn_rx <= 1))
    else stop_with_error($sformatf("FAIL io_tkn_o count 0x%h, mem_tkn_o count 0x%h, limit 0x1",
                                   io_tkn_rx, mem_tkn_rx));

  // never more unanswered words than credits
  outstanding_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (io_rx_cnt - io_tkn_sent <= depth_lp) && (mem_rx_cnt - mem_tkn_sent <= depth_lp))
    else stop_with_error($sformatf("FAIL io words held 0x%h, mem words held 0x%h, limit 0x%h",
                                   io_rx_cnt - io_tkn_sent, mem_rx_cnt - mem_tkn_sent, depth_lp));

  task automatic wait_drain(input bit include_io);
    int waited;
    waited = 0;
    while (exp_mem.size() != 0 || mem_tkn_sent != mem_rx_cnt ||
           (include_io && (exp_io.size() != 0 || io_tkn_sent != io_rx_cnt)))
    begin
      @(posedge clk_i);
      waited++;
      if (waited > timeout_lp)
        stop_with_error("timed out waiting for the links to drain");
    end
  endtask

  task automatic wait_held_words();
    int waited;
    waited = 0;
    while (io_rx_cnt - io_tkn_sent != depth_lp || mem_rx_cnt - mem_tkn_sent != depth_lp)
    begin
      @(posedge clk_i);
      waited++;
      if (waited > timeout_lp)
        stop_with_error("timed out waiting for a full window of words");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    rst_i        = 1'b1;
    tag_en_i     = 1'b0;
    tag_data_i   = 1'b0;
    io_beat_i    = '0;
    mem_beat_i   = '0;
    rng_state[0] = 32'h8960ba1c;
    rng_state[1] = lcg_step(32'h8960ba1c);
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    // links start disabled so one word per link parks in the core
    fork
      send_burst(1'b0, 1);
      send_burst(1'b1, 1);
    join
    repeat (40) @(posedge clk_i);

    send_tag(tag_pkg::tag_client_io_offset_gp, 8'h5a, tag_len_lp);
    cur_offset = 8'h5a;
    send_tag(tag_pkg::tag_client_mem_mask_gp, 8'hc3, tag_len_lp);
    cur_mask = 8'hc3;
    send_tag(tag_pkg::tag_client_link_en_gp, 8'h03, tag_len_lp);
    boot_phase <= 1'b0;
    io_off     <= 1'b0;
    mem_off    <= 1'b0;
    fork
      send_burst(1'b0, 6);
      send_burst(1'b1, 6);
    join
    wait_drain(1'b1);

    // mask rewrite
    send_tag(tag_pkg::tag_client_mem_mask_gp, 8'h3c, tag_len_lp);
    cur_mask = 8'h3c;
    send_burst(1'b1, 6);
    wait_drain(1'b1);

    // back-pressure with one window out then a stall
    hold_tkn <= 1'b1;
    fork
      send_burst(1'b0, 8);
      send_burst(1'b1, 8);
    join
    wait_held_words();
    repeat (20) @(posedge clk_i);
    hold_tkn <= 1'b0;
    wait_drain(1'b1);

    // io off while mem keeps going
    send_tag(tag_pkg::tag_client_link_en_gp, 8'h02, tag_len_lp);
    io_off <= 1'b1;
    fork
      send_burst(1'b0, 5);
      send_burst(1'b1, 6);
    join
    wait_drain(1'b0);
    repeat (20) @(posedge clk_i);
    assert (exp_io.size() == 5)
      else stop_with_error($sformatf("FAIL io words held 0x%h, expected 0x5", exp_io.size()));
    send_tag(tag_pkg::tag_client_link_en_gp, 8'h03, tag_len_lp);
    io_off <= 1'b0;
    wait_drain(1'b1);

    // truncated offset packet must not land
    send_tag(tag_pkg::tag_client_io_offset_gp, 8'ha7, 6);
    // the next full packet still frames from its first bit
    send_tag(tag_pkg::tag_client_mem_mask_gp, 8'h96, tag_len_lp);
    cur_mask = 8'h96;
    fork
      send_burst(1'b0, 4);
      send_burst(1'b1, 4);
    join
    wait_drain(1'b1);

    // each word fed in left its ingress with exactly one token
    assert (io_tkn_rx == io_started)
      else stop_with_error($sformatf("FAIL io_tkn_o count 0x%h, expected 0x%h",
                                     io_tkn_rx, io_started));
    assert (mem_tkn_rx == mem_started)
      else stop_with_error($sformatf("FAIL mem_tkn_o count 0x%h, expected 0x%h",
                                     mem_tkn_rx, mem_started));

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* chip_top.sv */
`timescale 1ns/1ps

module chip_top
  (input  logic                     clk_i
  ,input  logic                     rst_i
  ,input  logic                     tag_en_i
  ,input  logic                     tag_data_i

  ,input  chip_cfg_pkg::link_beat_s io_beat_i
  ,output logic                     io_tkn_o
  ,output chip_cfg_pkg::link_beat_s io_beat_o
  ,input  logic                     io_tkn_i

  ,input  chip_cfg_pkg::link_beat_s mem_beat_i
  ,output logic                     mem_tkn_o
  ,output chip_cfg_pkg::link_beat_s mem_beat_o
  ,input  logic                     mem_tkn_i
  );

  // configuration registers from the tag master
  tag_pkg::tag_cfg_s       cfg_lo;

  // ingress to core, per link
  logic                    io_in_v_lo;
  chip_cfg_pkg::io_word_t  io_in_data_lo;
  logic                    io_in_ready_li;
  logic                    mem_in_v_lo;
  chip_cfg_pkg::mem_word_t mem_in_data_lo;
  logic                    mem_in_ready_li;

  // core to egress, per link
  logic                    io_out_v_lo;
  chip_cfg_pkg::io_word_t  io_out_data_lo;
  logic                    io_out_ready_li;
  logic                    mem_out_v_lo;
  chip_cfg_pkg::mem_word_t mem_out_data_lo;
  logic                    mem_out_ready_li;

  ////////////////////////////////////////////////////////////////////////////
  // tag master

  tag_master btm
    (.clk_i      ( clk_i      )
    ,.rst_i      ( rst_i      )
    ,.tag_en_i   ( tag_en_i   )
    ,.tag_data_i ( tag_data_i )
    ,.cfg_o      ( cfg_lo     )
    );

  ////////////////////////////////////////////////////////////////////////////
  // link input side

  link_ingress #(.payload_t( chip_cfg_pkg::io_word_t )) io_link_in
    (.clk_i       ( clk_i          )
    ,.rst_i       ( rst_i          )
    ,.beat_i      ( io_beat_i      )
    ,.tkn_o       ( io_tkn_o       )
    ,.v_o         ( io_in_v_lo     )
    ,.data_o      ( io_in_data_lo  )
    ,.ready_and_i ( io_in_ready_li )
    );

  link_ingress #(.payload_t( chip_cfg_pkg::mem_word_t )) mem_link_in
    (.clk_i       ( clk_i           )
    ,.rst_i       ( rst_i           )
    ,.beat_i      ( mem_beat_i      )
    ,.tkn_o       ( mem_tkn_o       )
    ,.v_o         ( mem_in_v_lo     )
    ,.data_o      ( mem_in_data_lo  )
    ,.ready_and_i ( mem_in_ready_li )
    );

  ////////////////////////////////////////////////////////////////////////////
  // core complex

  core_complex core
    (.clk_i           ( clk_i            )
    ,.rst_i           ( rst_i            )
    ,.cfg_i           ( cfg_lo           )
    ,.io_v_i          ( io_in_v_lo       )
    ,.io_data_i       ( io_in_data_lo    )
    ,.io_ready_and_o  ( io_in_ready_li   )
    ,.io_v_o          ( io_out_v_lo      )
    ,.io_data_o       ( io_out_data_lo   )
    ,.io_ready_and_i  ( io_out_ready_li  )
    ,.mem_v_i         ( mem_in_v_lo      )
    ,.mem_data_i      ( mem_in_data_lo   )
    ,.mem_ready_and_o ( mem_in_ready_li  )
    ,.mem_v_o         ( mem_out_v_lo     )
    ,.mem_data_o      ( mem_out_data_lo  )
    ,.mem_ready_and_i ( mem_out_ready_li )
    );

  ////////////////////////////////////////////////////////////////////////////
  // link output side

  // link enables from the tag registers gate each egress
  link_egress #(.payload_t( chip_cfg_pkg::io_word_t )) io_link_out
    (.clk_i       ( clk_i           )
    ,.rst_i       ( rst_i           )
    ,.en_i        ( cfg_lo.io_en    )
    ,.v_i         ( io_out_v_lo     )
    ,.data_i      ( io_out_data_lo  )
    ,.ready_and_o ( io_out_ready_li )
    ,.beat_o      ( io_beat_o       )
    ,.tkn_i       ( io_tkn_i        )
    );

  link_egress #(.payload_t( chip_cfg_pkg::mem_word_t )) mem_link_out
    (.clk_i       ( clk_i            )
    ,.rst_i       ( rst_i            )
    ,.en_i        ( cfg_lo.mem_en    )
    ,.v_i         ( mem_out_v_lo     )
    ,.data_i      ( mem_out_data_lo  )
    ,.ready_and_o ( mem_out_ready_li )
    ,.beat_o      ( mem_beat_o       )
    ,.tkn_i       ( mem_tkn_i        )
    );

endmodule

/* core_complex.sv */
`timescale 1ns/1ps

module core_complex
  (input  logic                    clk_i
  ,input  logic                    rst_i
  ,input  tag_pkg::tag_cfg_s       cfg_i

  ,input  logic                    io_v_i
  ,input  chip_cfg_pkg::io_word_t  io_data_i
  ,output logic                    io_ready_and_o
  ,output logic                    io_v_o
  ,output chip_cfg_pkg::io_word_t  io_data_o
  ,input  logic                    io_ready_and_i

  ,input  logic                    mem_v_i
  ,input  chip_cfg_pkg::mem_word_t mem_data_i
  ,output logic                    mem_ready_and_o
  ,output logic                    mem_v_o
  ,output chip_cfg_pkg::mem_word_t mem_data_o
  ,input  logic                    mem_ready_and_i
  );

  // mask byte copies per mem word
  localparam int mask_reps_lp = $bits(chip_cfg_pkg::mem_word_t) / tag_pkg::tag_payload_width_gp;

  chip_cfg_pkg::io_word_t  io_xform;
  chip_cfg_pkg::mem_word_t mem_xform;

  // zero-extended offset with the sum wrapping at the word width
  assign io_xform  = io_data_i + chip_cfg_pkg::io_word_t'(cfg_i.io_offset);
  assign mem_xform = mem_data_i ^ {mask_reps_lp{cfg_i.mem_mask}};

  ////////////////////////////////////////////////////////////////////////////
  // single-entry stages

  // a full stage refills in the cycle its word leaves
  assign io_ready_and_o  = !io_v_o || io_ready_and_i;
  assign mem_ready_and_o = !mem_v_o || mem_ready_and_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      io_v_o  <= 1'b0;
      mem_v_o <= 1'b0;
    end
    else
    begin
      if (io_ready_and_o)
        io_v_o <= io_v_i;
      if (mem_ready_and_o)
        mem_v_o <= mem_v_i;
    end
  end

  // transformed payload captured with the handshake
  always_ff @(posedge clk_i)
  begin
    if (io_v_i && io_ready_and_o)
      io_data_o <= io_xform;
    if (mem_v_i && mem_ready_and_o)
      mem_data_o <= mem_xform;
  end

endmodule

/* link_egress.sv */
`timescale 1ns/1ps

module link_egress
  #(parameter type payload_t = chip_cfg_pkg::io_word_t)
  (input  logic                     clk_i
  ,input  logic                     rst_i
  ,input  logic                     en_i
  ,input  logic                     v_i
  ,input  payload_t                 data_i
  ,output logic                     ready_and_o
  ,output chip_cfg_pkg::link_beat_s beat_o
  ,input  logic                     tkn_i
  );

  localparam int ch_width_lp       = chip_cfg_pkg::channel_width_gp;
  localparam int width_lp          = $bits(payload_t);
  localparam int beats_lp          = width_lp / ch_width_lp;
  localparam int beat_cnt_width_lp = (beats_lp > 1) ? $clog2(beats_lp) : 1;
  localparam int depth_lp          = chip_cfg_pkg::link_fifo_depth_gp;
  localparam int credit_width_lp   = $clog2(depth_lp + 1);

  // one credit per free word slot in the partner fifo
  logic [credit_width_lp-1:0]   credit_r;
  logic [width_lp-1:0]          shift_r;
  logic [beat_cnt_width_lp-1:0] beat_cnt_r;
  logic                         busy_r;
  logic                         accept;
  logic                         last_beat;

  // idle, a credit in hand and the link switched on
  assign ready_and_o = en_i && !busy_r && (credit_r != '0);
  assign accept      = v_i && ready_and_o;
  assign last_beat   = busy_r && (beat_cnt_r == beat_cnt_width_lp'(beats_lp - 1));

  // low slice of the shift register is the beat on the wire
  assign beat_o = '{v: busy_r, data: shift_r[ch_width_lp-1:0]};

  ////////////////////////////////////////////////////////////////////////////
  // beat serializer

  // word loads on accept, then drops one channel slice per cycle
  always_ff @(posedge clk_i)
  begin
    if (accept)
      shift_r <= width_lp'(data_i);
    else if (busy_r)
      shift_r <= shift_r >> ch_width_lp;
  end

  // beats leave back to back, no gaps inside a word
  always_ff @(posedge clk_i)
  begin
    if (rst_i || last_beat)
    begin
      busy_r     <= 1'b0;
      beat_cnt_r <= '0;
    end
    else if (accept)
    begin
      busy_r     <= 1'b1;
      beat_cnt_r <= '0;
    end
    else if (busy_r)
      beat_cnt_r <= beat_cnt_r + 1'b1;
  end

  // credit counter
  // word taken spends one, token pulse returns one
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      credit_r <= credit_width_lp'(depth_lp);
    else
    begin
      case ({accept, tkn_i})
        2'b10:   credit_r <= credit_r - 1'b1;
        2'b01:   credit_r <= credit_r + 1'b1;
        default: credit_r <= credit_r;
      endcase
    end
  end

  // partner never returns more tokens than words it was sent
  credit_bound_a: assert property (@(posedge clk_i) disable iff (rst_i)
    credit_r <= credit_width_lp'(depth_lp));

endmodule

/* link_ingress.sv */
`timescale 1ns/1ps

module link_ingress
  #(parameter type payload_t = chip_cfg_pkg::io_word_t)
  (input  logic                     clk_i
  ,input  logic                     rst_i
  ,input  chip_cfg_pkg::link_beat_s beat_i
  ,output logic                     tkn_o
  ,output logic                     v_o
  ,output payload_t                 data_o
  ,input  logic                     ready_and_i
  );

  localparam int ch_width_lp       = chip_cfg_pkg::channel_width_gp;
  localparam int width_lp          = $bits(payload_t);
  localparam int beats_lp          = width_lp / ch_width_lp;
  localparam int beat_cnt_width_lp = (beats_lp > 1) ? $clog2(beats_lp) : 1;
  localparam int depth_lp          = chip_cfg_pkg::link_fifo_depth_gp;
  localparam int ptr_width_lp      = $clog2(depth_lp);
  localparam int count_width_lp    = $clog2(depth_lp + 1);

  ////////////////////////////////////////////////////////////////////////////
  // beat reassembly

  // earlier beats of the current word, newest at the top
  logic [width_lp-ch_width_lp-1:0] part_r;
  logic [width_lp-1:0]             word_n;
  logic [beat_cnt_width_lp-1:0]    beat_cnt_r;
  logic                            word_done;

  // live beat lands on top, first beat ends up least significant
  assign word_n    = {beat_i.data, part_r};
  assign word_done = beat_i.v && (beat_cnt_r == beat_cnt_width_lp'(beats_lp - 1));

  always_ff @(posedge clk_i)
  begin
    if (beat_i.v)
      part_r <= word_n[width_lp-1:ch_width_lp];
  end

  // gaps between beats just hold the count
  always_ff @(posedge clk_i)
  begin
    if (rst_i || word_done)
      beat_cnt_r <= '0;
    else if (beat_i.v)
      beat_cnt_r <= beat_cnt_r + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // word fifo

  payload_t                  fifo_mem_r [depth_lp];
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic                      fifo_full;
  logic                      pop;

  assign fifo_full = (count_r == count_width_lp'(depth_lp));
  assign v_o       = (count_r != '0);
  assign data_o    = fifo_mem_r[rd_ptr_r];
  assign pop       = v_o && ready_and_i;

  // every word handed to the core frees one partner credit
  assign tkn_o = pop;

  // completed word written on the edge of its last beat
  always_ff @(posedge clk_i)
  begin
    if (word_done)
      fifo_mem_r[wr_ptr_r] <= payload_t'(word_n);
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (word_done)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(depth_lp - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(depth_lp - 1)) ? '0 : rd_ptr_r + 1'b1;
      case ({word_done, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // partner credit rules keep a finished word off a full fifo
  no_overflow_a: assert property (@(posedge clk_i) disable iff (rst_i)
    word_done |-> !fifo_full);

endmodule

/* tag_master.sv */
`timescale 1ns/1ps

module tag_master
  (input  logic              clk_i
  ,input  logic              rst_i
  ,input  logic              tag_en_i
  ,input  logic              tag_data_i
  ,output tag_pkg::tag_cfg_s cfg_o
  );

  localparam int len_lp       = tag_pkg::tag_packet_len_gp;
  localparam int cnt_width_lp = $clog2(len_lp + 1);

  // packet shift register
  // after the last bit the id sits in the top bits
  logic [len_lp-1:0]                        pkt_r;
  logic [cnt_width_lp-1:0]                  cnt_r;
  logic                                     pkt_done;
  logic [tag_pkg::tag_id_width_gp-1:0]      pkt_id;
  logic [tag_pkg::tag_payload_width_gp-1:0] pkt_payload;
  tag_pkg::tag_cfg_s                        cfg_r;

  assign pkt_done    = (cnt_r == cnt_width_lp'(len_lp));
  assign pkt_id      = pkt_r[len_lp-1 -: tag_pkg::tag_id_width_gp];
  assign pkt_payload = pkt_r[tag_pkg::tag_payload_width_gp-1:0];
  assign cfg_o       = cfg_r;

  // serial bits enter at the lsb end
  always_ff @(posedge clk_i)
  begin
    if (tag_en_i)
      pkt_r <= {pkt_r[len_lp-2:0], tag_data_i};
  end

  // bit counter
  // a low enable mid packet throws the partial packet away
  // back to back packets restart at one
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      cnt_r <= '0;
    else if (pkt_done)
      cnt_r <= tag_en_i ? cnt_width_lp'(1) : '0;
    else if (tag_en_i)
      cnt_r <= cnt_r + 1'b1;
    else
      cnt_r <= '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // client register writes

  // one edge after the tenth bit
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      cfg_r <= '0;
    else if (pkt_done)
    begin
      case (pkt_id)
        tag_pkg::tag_client_io_offset_gp: cfg_r.io_offset <= pkt_payload;
        tag_pkg::tag_client_mem_mask_gp:  cfg_r.mem_mask  <= pkt_payload;
        tag_pkg::tag_client_link_en_gp:
        begin
          cfg_r.io_en  <= pkt_payload[0];
          cfg_r.mem_en <= pkt_payload[1];
        end
        // packet for the unused id is dropped
        default: cfg_r <= cfg_r;
      endcase
    end
  end

  // counter stops at one full packet
  cnt_bound_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_r <= cnt_width_lp'(len_lp));

endmodule

/* tag_pkg.sv */
package tag_pkg;

  // packet layout
  // id goes out first then the payload, both msb first
  localparam int tag_id_width_gp      = 2;
  localparam int tag_payload_width_gp = 8;
  localparam int tag_packet_len_gp    = tag_id_width_gp + tag_payload_width_gp;

  // client ids, id 3 has no client behind it
  localparam logic [tag_id_width_gp-1:0] tag_client_io_offset_gp = 2'd0;
  localparam logic [tag_id_width_gp-1:0] tag_client_mem_mask_gp  = 2'd1;
  localparam logic [tag_id_width_gp-1:0] tag_client_link_en_gp   = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // client register file

  // io_offset added to io words
  // mem_mask xor-ed into every byte of a mem word
  // io_en and mem_en gate the two egress ports
  typedef struct packed
  {
    logic [tag_payload_width_gp-1:0] io_offset;
    logic [tag_payload_width_gp-1:0] mem_mask;
    logic                            io_en;
    logic                            mem_en;
  } tag_cfg_s;

endpackage

/* chip_cfg_pkg.sv */
package chip_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // link geometry

  // bits carried by one beat on either link
  localparam int channel_width_gp = 8;

  // words held by each ingress fifo
  // egress credit counters start at the same value
  localparam int link_fifo_depth_gp = 4;

  // word widths of the two off-chip links
  localparam int io_word_width_gp  = 16;
  localparam int mem_word_width_gp = 32;

  ////////////////////////////////////////////////////////////////////////////
  // payload types

  // io link word, two beats
  typedef logic [io_word_width_gp-1:0] io_word_t;

  // mem link word, four beats
  typedef logic [mem_word_width_gp-1:0] mem_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // link wire bundle

  // one beat as seen on the link wires
  // v marks a live beat, data is one channel slice of a word
  typedef struct packed
  {
    logic                        v;
    logic [channel_width_gp-1:0] data;
  } link_beat_s;

endpackage
